// ==== hdl/eu_config.svh ====
`ifndef EU_CONFIG_SVH
`define EU_CONFIG_SVH

// Number of vector lanes in the cluster
`define EU_NUM_LANES 4

// SDRAM word address width
`define EU_ADDR_W 24

// SDRAM data width, four 32-bit elements per word
`define EU_SDRAM_W 128

// Lane index width, at least one bit
`define EU_LANE_W ((`EU_NUM_LANES > 1) ? $clog2(`EU_NUM_LANES) : 1)

`endif

// ==== hdl/eu_mem_pkg.sv ====
`include "eu_config.svh"

package eu_mem_pkg;

    ////////////////////////////////////////
    // SDRAM read port
    ////////////////////////////////////////

    // One-cycle request with a word address
    typedef struct packed {
        logic                  req;
        logic [`EU_ADDR_W-1:0] addr;
    } sdram_rd_req_t;

    // Exactly one valid strobe per request
    typedef struct packed {
        logic                   valid;
        logic [`EU_SDRAM_W-1:0] data;
    } sdram_rd_rsp_t;

endpackage

// ==== hdl/eu_types_pkg.sv ====
package eu_types_pkg;

    // Data layout of one SDRAM word
    localparam int EU_ELEM_W         = 32;
    localparam int EU_ELEMS_PER_WORD = 4;

    // Reduction opcodes
    typedef enum logic [1:0] {
        EU_OP_SUM      = 2'd0,
        EU_OP_MAX      = 2'd1,
        EU_OP_RELU_SUM = 2'd2
    } eu_op_e;

    // Fetch means the lane still waits for its first word
    typedef enum logic [1:0] {
        LANE_IDLE  = 2'd0,
        LANE_FETCH = 2'd1,
        LANE_EXEC  = 2'd2
    } lane_state_e;

    typedef struct packed {
        logic                        valid;
        logic signed [EU_ELEM_W-1:0] value;
    } lane_result_t;

endpackage

// ==== hdl/eu_fetch_arbiter.sv ====
`timescale 1ns/1ps
`include "eu_config.svh"

module eu_fetch_arbiter import eu_mem_pkg::*; (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic [`EU_NUM_LANES-1:0] i_fetch,
    input  logic [`EU_ADDR_W-1:0]    i_fetch_base,
    input  sdram_rd_rsp_t            i_rd,
    output sdram_rd_req_t            o_rd,
    output logic [`EU_NUM_LANES-1:0] o_load,
    output logic [`EU_SDRAM_W-1:0]   o_load_data,
    output logic                     o_fetch_done
);

    localparam int NUM_LANES = `EU_NUM_LANES;
    localparam int LANE_W    = `EU_LANE_W;

    logic [NUM_LANES-1:0]  pending_q;
    logic [`EU_ADDR_W-1:0] base_q;
    logic                  outstanding_q;
    logic [LANE_W-1:0]     cur_lane_q;
    logic [LANE_W-1:0]     next_lane;
    logic                  req_q;
    logic [`EU_ADDR_W-1:0] addr_q;
    logic                  issue;
    logic                  rsp_hit;

    // Lowest pending lane goes first
    always_comb begin
        next_lane = '0;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (pending_q[k]) begin
                next_lane = LANE_W'(k);
            end
        end
    end

    assign issue   = !outstanding_q && (pending_q != '0);
    assign rsp_hit = outstanding_q && i_rd.valid;

    ////////////////////////////////////////
    // Pending mask
    ////////////////////////////////////////

    // New fetch only accepted once the previous one drained
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pending_q <= '0;
        end else if (pending_q == '0) begin
            pending_q <= i_fetch;
        end else if (rsp_hit) begin
            pending_q[cur_lane_q] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if ((pending_q == '0) && (i_fetch != '0)) begin
            base_q <= i_fetch_base;
        end
    end

    ////////////////////////////////////////
    // SDRAM read issue
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            req_q         <= 1'b0;
            outstanding_q <= 1'b0;
        end else begin
            req_q <= issue;
            if (issue) begin
                outstanding_q <= 1'b1;
            end else if (rsp_hit) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q     <= base_q + `EU_ADDR_W'(next_lane);
            cur_lane_q <= next_lane;
        end
    end

    assign o_rd.req  = req_q;
    assign o_rd.addr = addr_q;

    ////////////////////////////////////////
    // Load routing and fetch done
    ////////////////////////////////////////

    // Done one cycle after the last load strobe
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_load       <= '0;
            o_fetch_done <= 1'b0;
        end else begin
            o_load <= '0;
            if (rsp_hit) begin
                o_load[cur_lane_q] <= 1'b1;
            end
            o_fetch_done <= (o_load != '0) && (pending_q == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            o_load_data <= i_rd.data;
        end
    end

endmodule

// ==== hdl/eu_lane.sv ====
`timescale 1ns/1ps
`include "eu_config.svh"

module eu_lane import eu_types_pkg::*; (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_load,
    input  logic [`EU_SDRAM_W-1:0] i_load_data,
    input  logic                   i_exec,
    input  eu_op_e                 i_op,
    output logic                   o_busy,
    output lane_result_t           o_result
);

    localparam int CNT_W = $clog2(EU_ELEMS_PER_WORD);
    localparam logic signed [EU_ELEM_W-1:0] ELEM_MIN = {1'b1, {(EU_ELEM_W - 1){1'b0}}};

    lane_state_e                 state_q;
    logic [`EU_SDRAM_W-1:0]      word_q;
    logic [`EU_SDRAM_W-1:0]      walk_q;
    eu_op_e                      op_q;
    eu_op_e                      cur_op;
    logic [CNT_W-1:0]            cnt_q;
    logic signed [EU_ELEM_W-1:0] acc_q;
    logic signed [EU_ELEM_W-1:0] acc_in;
    logic signed [EU_ELEM_W-1:0] elem;
    logic signed [EU_ELEM_W-1:0] acc_nxt;
    logic                        start;
    logic                        last;
    logic                        res_valid_q;

    assign start  = i_exec && (state_q == LANE_IDLE);
    assign last   = (state_q == LANE_EXEC) && (cnt_q == CNT_W'(EU_ELEMS_PER_WORD - 1));
    assign o_busy = (state_q != LANE_IDLE);

    ////////////////////////////////////////
    // Reduction step
    ////////////////////////////////////////

    // Element 0 is folded in on the exec cycle itself
    always_comb begin
        if (state_q == LANE_EXEC) begin
            cur_op = op_q;
            elem   = walk_q[EU_ELEM_W-1:0];
            acc_in = acc_q;
        end else begin
            cur_op = i_op;
            elem   = word_q[EU_ELEM_W-1:0];
            acc_in = (i_op == EU_OP_MAX) ? ELEM_MIN : '0;
        end

        case (cur_op)
            EU_OP_MAX:      acc_nxt = (elem > acc_in) ? elem : acc_in;
            EU_OP_RELU_SUM: acc_nxt = elem[EU_ELEM_W-1] ? acc_in : acc_in + elem;
            default:        acc_nxt = acc_in + elem;
        endcase
    end

    ////////////////////////////////////////
    // Lane FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q     <= LANE_FETCH;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= last;
            case (state_q)
                LANE_FETCH: if (i_load) state_q <= LANE_IDLE;
                LANE_IDLE:  if (i_exec) state_q <= LANE_EXEC;
                LANE_EXEC:  if (last) state_q <= LANE_IDLE;
                default:    state_q <= LANE_FETCH;
            endcase
        end
    end

    // Word may be reloaded during exec, the walk uses its own copy
    always_ff @(posedge clk) begin
        if (i_load) begin
            word_q <= i_load_data;
        end
        if (start) begin
            op_q   <= i_op;
            walk_q <= word_q >> EU_ELEM_W;
            cnt_q  <= CNT_W'(1);
            acc_q  <= acc_nxt;
        end else if (state_q == LANE_EXEC) begin
            walk_q <= walk_q >> EU_ELEM_W;
            cnt_q  <= cnt_q + 1'b1;
            acc_q  <= acc_nxt;
        end
    end

    assign o_result.valid = res_valid_q;
    assign o_result.value = acc_q;

endmodule

// ==== hdl/eu_result_collector.sv ====
`timescale 1ns/1ps
`include "eu_config.svh"

module eu_result_collector import eu_types_pkg::*; (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic [`EU_NUM_LANES-1:0]    i_exec,
    input  lane_result_t                i_results [`EU_NUM_LANES],
    output logic                        o_res_valid,
    output logic [`EU_LANE_W-1:0]       o_res_lane,
    output logic signed [EU_ELEM_W-1:0] o_res_data,
    output logic [`EU_NUM_LANES-1:0]    o_exec_done
);

    localparam int NUM_LANES = `EU_NUM_LANES;
    localparam int LANE_W    = `EU_LANE_W;

    logic [NUM_LANES-1:0]        slot_valid_q;
    logic signed [EU_ELEM_W-1:0] slot_data_q [NUM_LANES];
    logic [NUM_LANES-1:0]        cand;
    logic [NUM_LANES-1:0]        grant;
    logic [LANE_W-1:0]           grant_lane;
    logic signed [EU_ELEM_W-1:0] grant_data;

    ////////////////////////////////////////
    // Fixed priority select
    ////////////////////////////////////////

    // A fresh strobe competes in the same cycle as the held slots
    always_comb begin
        grant      = '0;
        grant_lane = '0;
        grant_data = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            cand[k] = slot_valid_q[k] | i_results[k].valid;
        end
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (cand[k]) begin
                grant      = '0;
                grant[k]   = 1'b1;
                grant_lane = LANE_W'(k);
                grant_data = slot_valid_q[k] ? slot_data_q[k] : i_results[k].value;
            end
        end
    end

    ////////////////////////////////////////
    // Slots, output and done mask
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            slot_valid_q <= '0;
            o_res_valid  <= 1'b0;
            o_exec_done  <= '0;
        end else begin
            slot_valid_q <= cand & ~grant;
            o_res_valid  <= |cand;
            // Sticky until the lane is started again
            o_exec_done  <= (o_exec_done & ~i_exec) | grant;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (i_results[k].valid) begin
                slot_data_q[k] <= i_results[k].value;
            end
        end
        if (|cand) begin
            o_res_lane <= grant_lane;
            o_res_data <= grant_data;
        end
    end

endmodule

// ==== hdl/eu_top.sv ====
`timescale 1ns/1ps
`include "eu_config.svh"

module eu_top import eu_mem_pkg::*, eu_types_pkg::*; (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic [`EU_NUM_LANES-1:0]    i_fetch,
    input  logic [`EU_ADDR_W-1:0]       i_fetch_base,
    input  logic [`EU_NUM_LANES-1:0]    i_exec,
    input  eu_op_e                      i_exec_op,
    output sdram_rd_req_t               o_rd,
    input  sdram_rd_rsp_t               i_rd,
    output logic                        o_res_valid,
    output logic [`EU_LANE_W-1:0]       o_res_lane,
    output logic signed [EU_ELEM_W-1:0] o_res_data,
    output logic                        o_fetch_done,
    output logic [`EU_NUM_LANES-1:0]    o_exec_done
);

    logic [`EU_NUM_LANES-1:0] load;
    logic [`EU_SDRAM_W-1:0]   load_data;
    logic [`EU_NUM_LANES-1:0] lane_busy;
    logic [`EU_NUM_LANES-1:0] exec_idle;
    lane_result_t             results [`EU_NUM_LANES];

    // Exec reaches idle lanes only
    assign exec_idle = i_exec & ~lane_busy;

    eu_fetch_arbiter u_fetch_arbiter (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_fetch      (i_fetch),
        .i_fetch_base (i_fetch_base),
        .i_rd         (i_rd),
        .o_rd         (o_rd),
        .o_load       (load),
        .o_load_data  (load_data),
        .o_fetch_done (o_fetch_done)
    );

    for (genvar k = 0; k < `EU_NUM_LANES; k++) begin : g_lane
        eu_lane u_lane (
            .clk         (clk),
            .i_rst       (i_rst),
            .i_load      (load[k]),
            .i_load_data (load_data),
            .i_exec      (exec_idle[k]),
            .i_op        (i_exec_op),
            .o_busy      (lane_busy[k]),
            .o_result    (results[k])
        );
    end

    eu_result_collector u_result_collector (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_exec      (exec_idle),
        .i_results   (results),
        .o_res_valid (o_res_valid),
        .o_res_lane  (o_res_lane),
        .o_res_data  (o_res_data),
        .o_exec_done (o_exec_done)
    );

endmodule

// ==== dv/eu_clk_gen.sv ====
`timescale 1ns/1ps

module eu_clk_gen (
    output logic o_clk
);

    // 4 ns period, low for the first half
    initial begin
        o_clk = 1'b0;
    end

    always #2 o_clk = ~o_clk;

endmodule

// ==== dv/eu_assertions.sv ====
`timescale 1ns/1ps
`include "eu_config.svh"

module eu_assertions import eu_mem_pkg::*; (
    input logic                     clk,
    input logic                     i_rst,
    input sdram_rd_req_t            i_rd_req,
    input sdram_rd_rsp_t            i_rd_rsp,
    input logic [`EU_NUM_LANES-1:0] i_exec,
    input logic                     i_res_valid,
    input logic [`EU_LANE_W-1:0]    i_res_lane
);

    int unsigned              fail_cnt = 0;
    logic                     rst_held_q = 1'b0;
    logic [1:0]               rd_open_q;
    logic [`EU_NUM_LANES-1:0] emitted_q;

    ////////////////////////////////////////
    // Protocol trackers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        rst_held_q <= i_rst;
        if (i_rst) begin
            rd_open_q <= '0;
            emitted_q <= '0;
        end else begin
            if (i_rd_req.req && !i_rd_rsp.valid) begin
                rd_open_q <= rd_open_q + 2'd1;
            end else if (!i_rd_req.req && i_rd_rsp.valid) begin
                rd_open_q <= rd_open_q - 2'd1;
            end
            // A new exec re-arms the lane
            emitted_q <= emitted_q & ~i_exec;
            if (i_res_valid) begin
                emitted_q[i_res_lane] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_one_read: assert property (@(posedge clk) disable iff (i_rst)
        i_rd_req.req |-> (rd_open_q == 2'd0))
        else begin
            $error("SDRAM read issued while another read is outstanding");
            fail_cnt++;
        end

    // First edge of reset skipped, the request register is still unknown
    a_no_req_in_reset: assert property (@(posedge clk)
        (i_rst && rst_held_q) |-> !i_rd_req.req)
        else begin
            $error("SDRAM read request while reset is held");
            fail_cnt++;
        end

    a_one_result_per_exec: assert property (@(posedge clk) disable iff (i_rst)
        i_res_valid |-> !emitted_q[i_res_lane])
        else begin
            $error("second result from lane %0d without a new exec", i_res_lane);
            fail_cnt++;
        end

endmodule

bind eu_top eu_assertions u_eu_assertions (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_rd_req    (o_rd),
    .i_rd_rsp    (i_rd),
    .i_exec      (i_exec),
    .i_res_valid (o_res_valid),
    .i_res_lane  (o_res_lane)
);

// ==== dv/eu_tb.sv ====
`timescale 1ns/1ps
`include "eu_config.svh"

module eu_tb import eu_mem_pkg::*, eu_types_pkg::*; ();

    localparam int NUM_LANES     = `EU_NUM_LANES;
    localparam int FETCH_TIMEOUT = 200;
    localparam int EXEC_TIMEOUT  = 60;

    logic                        clk;
    logic                        rst;
    logic [NUM_LANES-1:0]        fetch;
    logic [`EU_ADDR_W-1:0]       fetch_base;
    logic [NUM_LANES-1:0]        exec;
    eu_op_e                      exec_op;
    sdram_rd_req_t               rd_req;
    sdram_rd_rsp_t               rd_rsp;
    logic                        res_valid;
    logic [`EU_LANE_W-1:0]       res_lane;
    logic signed [EU_ELEM_W-1:0] res_data;
    logic                        fetch_done;
    logic [NUM_LANES-1:0]        exec_done;

    integer                seed = 32'h20047226;
    int                    n_err;
    int                    n_tests;
    int                    n_bad;
    logic [`EU_ADDR_W-1:0] lane_addr [NUM_LANES];
    logic [NUM_LANES-1:0]  exp_done;
    logic                  mem_busy;
    int                    mem_wait;
    logic [`EU_ADDR_W-1:0] mem_addr;

    eu_clk_gen u_clk_gen (
        .o_clk (clk)
    );

    eu_top dut (
        .clk          (clk),
        .i_rst        (rst),
        .i_fetch      (fetch),
        .i_fetch_base (fetch_base),
        .i_exec       (exec),
        .i_exec_op    (exec_op),
        .o_rd         (rd_req),
        .i_rd         (rd_rsp),
        .o_res_valid  (res_valid),
        .o_res_lane   (res_lane),
        .o_res_data   (res_data),
        .o_fetch_done (fetch_done),
        .o_exec_done  (exec_done)
    );

    ////////////////////////////////////////
    // Memory contents and reference model
    ////////////////////////////////////////

    // Hashes address and element index so about half the values are negative
    function automatic logic signed [EU_ELEM_W-1:0] elem_value(
        input logic [`EU_ADDR_W-1:0] addr,
        input int                    j
    );
        logic [31:0] mix;
        mix = {addr, 8'(j)} * 32'h9E37_79B1;
        return signed'(mix ^ (mix >> 15));
    endfunction

    function automatic logic [`EU_SDRAM_W-1:0] word_at(input logic [`EU_ADDR_W-1:0] addr);
        logic [`EU_SDRAM_W-1:0] w;
        for (int j = 0; j < EU_ELEMS_PER_WORD; j++) begin
            w[j*EU_ELEM_W +: EU_ELEM_W] = elem_value(addr, j);
        end
        return w;
    endfunction

    function automatic logic signed [EU_ELEM_W-1:0] expected_result(
        input logic [`EU_ADDR_W-1:0] addr,
        input eu_op_e                op
    );
        logic signed [EU_ELEM_W-1:0] acc;
        logic signed [EU_ELEM_W-1:0] e;
        acc = (op == EU_OP_MAX) ? 32'sh8000_0000 : 32'sd0;
        for (int j = 0; j < EU_ELEMS_PER_WORD; j++) begin
            e = elem_value(addr, j);
            case (op)
                EU_OP_MAX:      acc = (e > acc) ? e : acc;
                EU_OP_RELU_SUM: acc = (e > 0) ? acc + e : acc;
                default:        acc = acc + e;
            endcase
        end
        return acc;
    endfunction

    // SDRAM read port with 1 to 8 cycles of latency
    always @(negedge clk) begin
        rd_rsp.valid = 1'b0;
        if (mem_busy) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                rd_rsp.valid = 1'b1;
                rd_rsp.data  = word_at(mem_addr);
                mem_busy     = 1'b0;
            end
        end
        if (rd_req.req) begin
            mem_busy = 1'b1;
            mem_addr = rd_req.addr;
            mem_wait = 1 + ($unsigned($random(seed)) % 8);
        end
    end

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        n_err++;
    endtask

    task automatic finish_test(input string name, input int err_at_start);
        n_tests++;
        if (n_err == err_at_start) begin
            $display("Test %0d %s: ok", n_tests, name);
        end else begin
            n_bad++;
            $display("Test %0d %s: %0d errors", n_tests, name, n_err - err_at_start);
        end
    endtask

    ////////////////////////////////////////
    // Fetch and exec sequences
    ////////////////////////////////////////

    task automatic run_fetch(
        input logic [NUM_LANES-1:0]  mask,
        input logic [`EU_ADDR_W-1:0] base,
        input logic [NUM_LANES-1:0]  late_mask
    );
        logic [`EU_ADDR_W-1:0] reads [$];
        int                    pulses;
        int                    tail;
        int                    idx;
        pulses     = 0;
        tail       = -1;
        idx        = 0;
        fetch      = mask;
        fetch_base = base;
        for (int cyc = 0; cyc < FETCH_TIMEOUT && tail < 3; cyc++) begin
            @(negedge clk);
            // Late strobe lands while the first fetch is still pending
            fetch      = (cyc == 0) ? late_mask : '0;
            fetch_base = ~base;
            if (rd_req.req) begin
                reads.push_back(rd_req.addr);
            end
            if (fetch_done) begin
                pulses++;
            end
            if (tail >= 0) begin
                tail++;
            end else if (pulses > 0) begin
                tail = 0;
            end
        end
        if (pulses == 0) begin
            $display("Timeout: o_fetch_done did not pulse within %0d cycles", FETCH_TIMEOUT);
            n_err++;
        end else begin
            assert (pulses == 1)
                else report_mismatch($sformatf("o_fetch_done pulsed %0d times", pulses));
        end
        assert (reads.size() == $countones(mask))
            else report_mismatch($sformatf("%0d SDRAM reads, expected %0d",
                                           reads.size(), $countones(mask)));
        for (int k = 0; k < NUM_LANES; k++) begin
            if (mask[k]) begin
                lane_addr[k] = base + `EU_ADDR_W'(k);
                if (idx < reads.size()) begin
                    assert (reads[idx] == lane_addr[k])
                        else report_mismatch($sformatf("read %0d at %h, expected %h",
                                                       idx, reads[idx], lane_addr[k]));
                end
                idx++;
            end
        end
    endtask

    task automatic run_exec(
        input logic [NUM_LANES-1:0] mask,
        input eu_op_e               op,
        input logic [NUM_LANES-1:0] busy_mask
    );
        int                          lanes [$];
        int                          got;
        int                          tail;
        logic signed [EU_ELEM_W-1:0] want;
        got  = 0;
        tail = -1;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (mask[k]) begin
                lanes.push_back(k);
            end
        end
        exec     = mask;
        exec_op  = op;
        exp_done = exp_done & ~mask;
        for (int cyc = 0; cyc < EXEC_TIMEOUT && tail < 8; cyc++) begin
            @(negedge clk);
            // Repeat strobe hits lanes that are still walking their word
            exec = (cyc == 1) ? busy_mask : '0;
            if (cyc == 0) begin
                assert (exec_done == exp_done)
                    else report_mismatch($sformatf("exec_done %b after exec, expected %b",
                                                   exec_done, exp_done));
            end
            if (res_valid && got >= lanes.size()) begin
                report_mismatch($sformatf("extra result from lane %0d", res_lane));
            end else if (res_valid) begin
                want = expected_result(lane_addr[lanes[got]], op);
                // Lane strobe comes 4 cycles after exec and is emitted one cycle later
                assert (got > 0 || cyc + 1 == 5)
                    else report_mismatch($sformatf("first result %0d cycles after exec",
                                                   cyc + 1));
                assert (res_lane == lanes[got])
                    else report_mismatch($sformatf("result from lane %0d, expected lane %0d",
                                                   res_lane, lanes[got]));
                assert (res_data == want)
                    else report_mismatch($sformatf("lane %0d result %0d, expected %0d",
                                                   lanes[got], res_data, want));
                exp_done[lanes[got]] = 1'b1;
                assert (exec_done == exp_done)
                    else report_mismatch($sformatf("exec_done %b, expected %b",
                                                   exec_done, exp_done));
            end
            if (res_valid) begin
                got++;
            end
            if (tail >= 0) begin
                tail++;
            end else if (got >= lanes.size()) begin
                tail = 0;
            end
        end
        if (got < lanes.size()) begin
            $display("Timeout: only %0d of %0d lane results arrived", got, lanes.size());
            n_err++;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int err0;
        int n_assert;
        rst        = 1'b1;
        fetch      = '0;
        fetch_base = '0;
        exec       = '0;
        exec_op    = EU_OP_SUM;
        rd_rsp     = '0;
        mem_busy   = 1'b0;
        mem_wait   = 0;
        n_err      = 0;
        n_tests    = 0;
        n_bad      = 0;
        exp_done   = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err0 = n_err;
        @(negedge clk);
        assert (fetch_done === 1'b0 && res_valid === 1'b0 &&
                exec_done === '0 && rd_req.req === 1'b0)
            else report_mismatch($sformatf("after reset fetch_done=%b res_valid=%b %s=%b rd=%b",
                                           fetch_done, res_valid, "exec_done",
                                           exec_done, rd_req.req));
        finish_test("reset state", err0);

        err0 = n_err;
        run_fetch('1, 24'h00_3A10, '0);
        finish_test("fetch all lanes", err0);

        // Partial masks first, while the unselected done bits are still clear
        err0 = n_err;
        run_exec(NUM_LANES'(5), EU_OP_MAX, '0);
        run_exec(NUM_LANES'(10), EU_OP_RELU_SUM, '0);
        finish_test("max and relu sum on partial masks", err0);

        err0 = n_err;
        run_exec('1, EU_OP_SUM, '0);
        finish_test("sum on all lanes", err0);

        err0 = n_err;
        run_fetch(NUM_LANES'(3), 24'h7F_FF00, '1);
        finish_test("fetch while pending", err0);

        err0 = n_err;
        run_exec(NUM_LANES'(3), EU_OP_SUM, NUM_LANES'(3));
        finish_test("exec to busy lanes", err0);

        n_assert = dut.u_eu_assertions.fail_cnt;
        $display("Tests run: %0d, tests failed: %0d, check errors: %0d, assertion failures: %0d",
                 n_tests, n_bad, n_err, n_assert);
        if (n_err == 0 && n_assert == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== eu_top.f ====
+incdir+hdl
hdl/eu_mem_pkg.sv
hdl/eu_types_pkg.sv
hdl/eu_fetch_arbiter.sv
hdl/eu_lane.sv
hdl/eu_result_collector.sv
hdl/eu_top.sv
dv/eu_clk_gen.sv
dv/eu_assertions.sv
dv/eu_tb.sv
